/* tail_light_pkg.sv */
package tail_light_pkg;

	// lamp modes shown on the matrix
	typedef enum logic [2:0]
	{
		GO,
		LEFT,
		RIGHT,
		STOP,
		OFF
	} lamp_mode_t;

	// button codes on state_in
	localparam logic [3:0] BTN_GO    = 4'b0000;
	localparam logic [3:0] BTN_LEFT  = 4'b0001;
	localparam logic [3:0] BTN_RIGHT = 4'b0010;
	localparam logic [3:0] BTN_STOP  = 4'b0100;

	localparam int MATRIX_W = 8;

	typedef logic [MATRIX_W-1:0] matrix_line_t;

	// seconds, 0 to 99
	typedef logic [6:0] sec_t;

	// segments a..g plus dp, msb is segment a
	localparam logic [7:0] seg_font [10] = '{
		8'b1111_1100,
		8'b0110_0000,
		8'b1101_1010,
		8'b1111_0010,
		8'b0110_0110,
		8'b1011_0110,
		8'b1011_1110,
		8'b1110_0000,
		8'b1111_1110,
		8'b1111_0110
	};

endpackage

/* lamp_status_if.sv */
`timescale 1ns/1ps

interface lamp_status_if;
	import tail_light_pkg::*;

	lamp_mode_t mode;
	logic       holding;
	sec_t       drive_sec;
	sec_t       hold_sec;

	modport fsm      (output mode, output holding, input hold_sec);
	modport counters (output drive_sec, output hold_sec, input mode, input holding);
	modport matrix   (input mode);
	modport display  (input mode, input drive_sec, input hold_sec);

endinterface

/* lamp_mode_fsm.sv */
`timescale 1ns/1ps

module lamp_mode_fsm #(
	parameter int HOLD_TURN_S = 10,
	parameter int HOLD_STOP_S = 5
) (
	input  logic        clkout_1Hz,
	input  logic        rst,
	input  logic        sw,
	input  logic [3:0]  state_in,
	lamp_status_if.fsm  status
);
	import tail_light_pkg::*;

	lamp_mode_t req_mode;
	sec_t       hold_last;
	logic       lit_mode;

	// switch and button decode
	always_comb
	begin
		if (!sw)
			req_mode = OFF;
		else
		begin
			case (state_in)
				BTN_GO:    req_mode = GO;
				BTN_LEFT:  req_mode = LEFT;
				BTN_RIGHT: req_mode = RIGHT;
				BTN_STOP:  req_mode = STOP;
				default:   req_mode = GO;
			endcase
		end
	end

	// last hold second before falling back to go
	always_comb
	begin
		if (status.mode == STOP)
			hold_last = sec_t'(HOLD_STOP_S - 1);
		else
			hold_last = sec_t'(HOLD_TURN_S - 1);
	end

	assign lit_mode = (status.mode == LEFT) || (status.mode == RIGHT) ||
		(status.mode == STOP);

	always_ff @(posedge clkout_1Hz)
	begin
		if (!rst)
		begin
			status.mode    <= GO;
			status.holding <= 1'b0;
		end
		else if (req_mode != GO)
		begin
			// off, or a fresh press, also cuts a running hold
			status.mode    <= req_mode;
			status.holding <= 1'b0;
		end
		else if (lit_mode && !status.holding)
		begin
			// release edge
			status.holding <= 1'b1;
		end
		else if (lit_mode && status.hold_sec != hold_last)
		begin
			status.holding <= 1'b1;
		end
		else
		begin
			status.mode    <= GO;
			status.holding <= 1'b0;
		end
	end

endmodule

/* second_counters.sv */
`timescale 1ns/1ps

module second_counters #(
	parameter int DRIVE_WRAP = 100
) (
	input  logic             clkout_1Hz,
	input  logic             rst,
	lamp_status_if.counters  status
);
	import tail_light_pkg::*;

	sec_t hold_cnt;

	always_ff @(posedge clkout_1Hz)
	begin
		if (!rst)
		begin
			status.drive_sec <= '0;
			hold_cnt         <= '0;
		end
		else
		begin
			// driving seconds only run in go
			if (status.mode != GO)
				status.drive_sec <= '0;
			else if (status.drive_sec == sec_t'(DRIVE_WRAP - 1))
				status.drive_sec <= '0;
			else
				status.drive_sec <= status.drive_sec + 7'd1;

			if (status.holding)
				hold_cnt <= hold_cnt + 7'd1;
			else
				hold_cnt <= '0;
		end
	end

	// reads 0 as soon as the hold ends or is cut
	assign status.hold_sec = status.holding ? hold_cnt : '0;

endmodule

/* matrix_driver.sv */
`timescale 1ns/1ps

module matrix_driver (
	input  logic                         clkout_1Hz,
	input  logic                         rst,
	lamp_status_if.matrix                status,
	output tail_light_pkg::matrix_line_t row,
	output tail_light_pkg::matrix_line_t col_r,
	output tail_light_pkg::matrix_line_t col_g
);
	import tail_light_pkg::*;

	logic [2:0]   scan;
	logic [2:0]   frame;
	logic [1:0]   arrow_idx;
	logic [1:0]   chev_idx;
	matrix_line_t chev_word;
	matrix_line_t arrow_base;
	matrix_line_t left_word;
	matrix_line_t right_word;
	matrix_line_t x_word;

	function automatic matrix_line_t rot_right(matrix_line_t w, logic [2:0] n);
		logic [2*MATRIX_W-1:0] d;
		d = {w, w} >> n;
		return d[MATRIX_W-1:0];
	endfunction

	always_ff @(posedge clkout_1Hz)
	begin
		if (!rst)
		begin
			scan  <= '0;
			frame <= '0;
		end
		else
		begin
			scan <= scan + 3'd1;
			// animation steps once per full scan
			if (scan == 3'd7)
				frame <= frame + 3'd1;
		end
	end

	assign row = ~(matrix_line_t'(1) << scan);

	// chevron repeats every four rows and scrolls down with frame
	assign chev_idx = scan[1:0] - frame[1:0];

	always_comb
	begin
		case (chev_idx)
			2'd0:    chev_word = 8'b1100_0011;
			2'd1:    chev_word = 8'b0110_0110;
			2'd2:    chev_word = 8'b0011_1100;
			default: chev_word = 8'b0001_1000;
		endcase
	end

	// arrow is mirrored about rows 3 and 4
	assign arrow_idx = scan[2] ? ~scan[1:0] : scan[1:0];

	always_comb
	begin
		case (arrow_idx)
			2'd0:    arrow_base = 8'b0000_1000;
			2'd1:    arrow_base = 8'b0000_1100;
			2'd2:    arrow_base = 8'b0000_0110;
			default: arrow_base = 8'b0111_1111;
		endcase
	end

	assign left_word  = rot_right(arrow_base, frame);
	// right arrow is the left one seen in a mirror
	assign right_word = {<<{left_word}};
	assign x_word     = (matrix_line_t'(1) << scan) | (matrix_line_t'(8'h80) >> scan);

	always_comb
	begin
		col_r = '0;
		col_g = '0;
		case (status.mode)
			GO:      col_g = chev_word;
			LEFT:    col_g = left_word;
			RIGHT:   col_g = right_word;
			STOP:    col_r = x_word;
			default: col_g = '0;
		endcase
	end

endmodule

/* segment_driver.sv */
`timescale 1ns/1ps

module segment_driver (
	input  logic            clkout_1Hz,
	input  logic            rst,
	lamp_status_if.display  status,
	output logic [7:0]      seg_row,
	output logic [7:0]      seg_col
);
	import tail_light_pkg::*;

	// active-low digit selects, left to right
	typedef enum logic [7:0]
	{
		DIG_DRIVE_TENS = 8'b0111_1111,
		DIG_DRIVE_ONES = 8'b1011_1111,
		DIG_HOLD_TENS  = 8'b1101_1111,
		DIG_HOLD_ONES  = 8'b1110_1111
	} digit_sel_t;

	digit_sel_t digit_sel;
	sec_t       value;
	logic [3:0] digit;

	always_ff @(posedge clkout_1Hz)
	begin
		if (!rst)
			digit_sel <= DIG_DRIVE_TENS;
		else
		begin
			case (digit_sel)
				DIG_DRIVE_TENS: digit_sel <= DIG_DRIVE_ONES;
				DIG_DRIVE_ONES: digit_sel <= DIG_HOLD_TENS;
				DIG_HOLD_TENS:  digit_sel <= DIG_HOLD_ONES;
				default:        digit_sel <= DIG_DRIVE_TENS;
			endcase
		end
	end

	always_comb
	begin
		if (digit_sel == DIG_DRIVE_TENS || digit_sel == DIG_DRIVE_ONES)
			value = status.drive_sec;
		else
			value = status.hold_sec;

		if (digit_sel == DIG_DRIVE_TENS || digit_sel == DIG_HOLD_TENS)
			digit = 4'(value / 7'd10);
		else
			digit = 4'(value % 7'd10);
	end

	// display dark while switched off
	always_comb
	begin
		if (status.mode == OFF)
		begin
			seg_row = 8'b1111_1111;
			seg_col = 8'b0000_0000;
		end
		else
		begin
			seg_row = digit_sel;
			seg_col = seg_font[digit];
		end
	end

endmodule

/* tail_light_top.sv */
`timescale 1ns/1ps

module tail_light_top #(
	parameter int HOLD_TURN_S = 10,
	parameter int HOLD_STOP_S = 5,
	parameter int DRIVE_WRAP  = 100
) (
	input  logic                         clkout_1Hz,
	input  logic                         rst,
	input  logic                         sw,
	input  logic [3:0]                   state_in,
	output tail_light_pkg::matrix_line_t row,
	output tail_light_pkg::matrix_line_t col_r,
	output tail_light_pkg::matrix_line_t col_g,
	output logic [7:0]                   seg_row,
	output logic [7:0]                   seg_col
);

	lamp_status_if status_if ();

	lamp_mode_fsm #(
		.HOLD_TURN_S (HOLD_TURN_S),
		.HOLD_STOP_S (HOLD_STOP_S)
	) i_lamp_mode_fsm (
		.clkout_1Hz (clkout_1Hz),
		.rst        (rst),
		.sw         (sw),
		.state_in   (state_in),
		.status     (status_if.fsm)
	);

	second_counters #(
		.DRIVE_WRAP (DRIVE_WRAP)
	) i_second_counters (
		.clkout_1Hz (clkout_1Hz),
		.rst        (rst),
		.status     (status_if.counters)
	);

	matrix_driver i_matrix_driver (
		.clkout_1Hz (clkout_1Hz),
		.rst        (rst),
		.status     (status_if.matrix),
		.row        (row),
		.col_r      (col_r),
		.col_g      (col_g)
	);

	segment_driver i_segment_driver (
		.clkout_1Hz (clkout_1Hz),
		.rst        (rst),
		.status     (status_if.display),
		.seg_row    (seg_row),
		.seg_col    (seg_col)
	);

endmodule

/* tail_light_asserts.sv */
`timescale 1ns/1ps

module tail_light_asserts (
	input logic       clkout_1Hz,
	input logic       rst,
	input logic       sw,
	input logic [7:0] row,
	input logic [7:0] col_r,
	input logic [7:0] col_g,
	input logic [7:0] seg_row
);

	// exactly one row selected
	one_row_selected: assert property (@(posedge clkout_1Hz) disable iff (!rst)
		$onehot(~row))
		else $error("row select does not have exactly one low bit");

	// red only in the stop X, never with green
	colours_exclusive: assert property (@(posedge clkout_1Hz) disable iff (!rst)
		!((col_r != 8'h00) && (col_g != 8'h00)))
		else $error("red and green columns lit together");

	switch_off_blanks_digits: assert property (@(posedge clkout_1Hz) disable iff (!rst)
		(!sw ##1 !sw) |-> (seg_row == 8'hFF))
		else $error("digit select active while switched off");

	reset_scan_row0: assert property (@(posedge clkout_1Hz)
		!rst |=> (row == 8'hFE))
		else $error("row scan not at row 0 after reset");

endmodule

bind tail_light_top tail_light_asserts i_tail_light_asserts (
	.clkout_1Hz (clkout_1Hz),
	.rst        (rst),
	.sw         (sw),
	.row        (row),
	.col_r      (col_r),
	.col_g      (col_g),
	.seg_row    (seg_row)
);

/* tail_light_tb.sv */
`timescale 1ns/1ps

module tail_light_tb;

	localparam int MAX_STEPS = 64;

	logic       clkout_1Hz;
	logic       rst;
	logic       sw;
	logic [3:0] state_in;
	logic [7:0] row;
	logic [7:0] col_r;
	logic [7:0] col_g;
	logic [7:0] seg_row;
	logic [7:0] seg_col;

	logic       step_rst    [MAX_STEPS];
	logic       step_sw     [MAX_STEPS];
	logic [3:0] step_btn    [MAX_STEPS];
	int         step_cycles [MAX_STEPS];
	int         step_mode   [MAX_STEPS];
	int         step_drive  [MAX_STEPS];
	int         step_hold   [MAX_STEPS];

	int n_steps = 0;
	int errors = 0;
	int cycle_cnt = 0;
	int cycle_limit = 100000;

	// reference scan position, digit select and frame
	logic [2:0] scan_m;
	logic [2:0] frame_m;
	logic [1:0] dig_m;

	logic [7:0] font [10] = '{
		8'hFC, 8'h60, 8'hDA, 8'hF2, 8'h66,
		8'hB6, 8'hBE, 8'hE0, 8'hFE, 8'hF6
	};

	tail_light_top i_tail_light_top (
		.clkout_1Hz (clkout_1Hz),
		.rst        (rst),
		.sw         (sw),
		.state_in   (state_in),
		.row        (row),
		.col_r      (col_r),
		.col_g      (col_g),
		.seg_row    (seg_row),
		.seg_col    (seg_col)
	);

	initial
	begin
		clkout_1Hz = 1'b0;
		forever #4 clkout_1Hz = ~clkout_1Hz;
	end

	always @(posedge clkout_1Hz)
	begin
		if (!rst)
		begin
			scan_m  <= '0;
			frame_m <= '0;
			dig_m   <= '0;
		end
		else
		begin
			scan_m <= scan_m + 3'd1;
			dig_m  <= dig_m + 2'd1;
			if (scan_m == 3'd7)
				frame_m <= frame_m + 3'd1;
		end
	end

	always @(posedge clkout_1Hz)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > cycle_limit)
		begin
			$display("timeout after %0d cycles, the test steps did not finish", cycle_cnt);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	function automatic logic [7:0] rotate_right(input logic [7:0] w, input int n);
		logic [7:0] r;
		for (int i = 0; i < 8; i++)
			r[i] = w[(i + n) % 8];
		return r;
	endfunction

	function automatic logic [7:0] rotate_left(input logic [7:0] w, input int n);
		return rotate_right(w, 8 - (n % 8));
	endfunction

	task automatic check_value(input string name, input int got, input int exp);
		assert (got == exp)
		else
		begin
			$display("FAILED at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic load_tests();
		int    fd;
		string line;
		int    r;
		int    s;
		int    b;
		int    c;
		int    m;
		int    d;
		int    h;
		fd = $fopen("tail_light_tests.txt", "r");
		if (fd == 0)
			$display("cannot open tail_light_tests.txt");
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() < 2 || line.substr(0, 0) == "#")
					continue;
				if ($sscanf(line, "%d %d %b %d %d %d %d", r, s, b, c, m, d, h) == 7
					&& n_steps < MAX_STEPS)
				begin
					step_rst[n_steps]    = r[0];
					step_sw[n_steps]     = s[0];
					step_btn[n_steps]    = b[3:0];
					step_cycles[n_steps] = c;
					step_mode[n_steps]   = m;
					step_drive[n_steps]  = d;
					step_hold[n_steps]   = h;
					n_steps++;
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic check_step(input int k);
		int         errs_before;
		logic [7:0] exp_word;
		int         val;
		int         digit;
		errs_before = errors;
		check_value("mode", i_tail_light_top.status_if.mode, step_mode[k]);
		check_value("drive_sec", i_tail_light_top.status_if.drive_sec, step_drive[k]);
		check_value("hold_sec", i_tail_light_top.status_if.hold_sec, step_hold[k]);
		exp_word = ~(8'h01 << scan_m);
		check_value("row", row, exp_word);
		case (step_mode[k])
			0:
			begin
				check_value("col_r", col_r, 0);
				assert (col_g != 8'h00)
				else
				begin
					$display("green chevron row is empty in go mode at %0t", $time);
					errors++;
				end
			end
			1, 2:
			begin
				check_value("col_r", col_r, 0);
				// arrow shaft rows
				if (scan_m == 3'd3 || scan_m == 3'd4)
				begin
					if (step_mode[k] == 1)
						exp_word = rotate_right(8'h7F, frame_m);
					else
						exp_word = rotate_left(8'h7F, frame_m + 1);
					check_value("col_g", col_g, exp_word);
				end
			end
			3:
			begin
				check_value("col_g", col_g, 0);
				exp_word = (8'h01 << scan_m) | (8'h01 << (3'd7 - scan_m));
				check_value("col_r", col_r, exp_word);
			end
			default:
			begin
				check_value("col_r", col_r, 0);
				check_value("col_g", col_g, 0);
			end
		endcase
		if (step_mode[k] == 4)
		begin
			check_value("seg_row", seg_row, 8'hFF);
			check_value("seg_col", seg_col, 0);
		end
		else
		begin
			val = (dig_m < 2'd2) ? step_drive[k] : step_hold[k];
			digit = dig_m[0] ? val % 10 : val / 10;
			exp_word = ~(8'h80 >> dig_m);
			check_value("seg_row", seg_row, exp_word);
			check_value("seg_col", seg_col, font[digit]);
		end
		if (errors == errs_before)
			$display("step %0d ok", k);
		else
			$display("step %0d failed", k);
	endtask

	initial
	begin
		int total;
		rst      = 1'b0;
		sw       = 1'b0;
		state_in = 4'b0000;
		load_tests();
		total = 0;
		for (int k = 0; k < n_steps; k++)
			total += step_cycles[k];
		cycle_limit = total + 8 + 50;
		repeat (8) @(negedge clkout_1Hz);
		for (int k = 0; k < n_steps; k++)
		begin
			rst      = step_rst[k];
			sw       = step_sw[k];
			state_in = step_btn[k];
			repeat (step_cycles[k]) @(negedge clkout_1Hz);
			check_step(k);
		end
		if (n_steps == 0)
		begin
			$display("no test steps were read");
			errors++;
		end
		$display("steps %0d, errors %0d", n_steps, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* tail_light_tests.txt */
# rst sw buttons cycles mode drive_sec hold_sec
# mode: 0 go, 1 left, 2 right, 3 stop, 4 off; values checked at step end
1 1 0000 20 0 20 0
1 1 0000 85 0 5 0
1 1 0001 3 1 0 0
1 1 0000 4 1 0 3
1 1 0000 5 1 0 8
1 1 0000 1 1 0 9
1 1 0000 1 0 0 0
1 1 0000 3 0 3 0
1 1 0010 2 2 0 0
1 1 0000 3 2 0 2
1 1 0100 1 3 0 0
1 1 0100 2 3 0 0
1 1 0000 5 3 0 4
1 1 0000 1 0 0 0
1 1 0000 2 0 2 0
1 0 0000 4 4 0 0
1 1 0000 1 0 0 0
1 1 0000 10 0 10 0
1 1 0001 1 1 11 0
1 1 0000 2 1 0 1
0 1 0000 3 0 0 0
1 1 0000 7 0 7 0
1 1 1000 4 0 11 0
1 1 0011 1 0 12 0
1 1 0001 13 1 0 0
1 1 0100 1 3 0 0
1 0 0100 2 4 0 0

/* vlog.f */
tail_light_pkg.sv
lamp_status_if.sv
lamp_mode_fsm.sv
second_counters.sv
matrix_driver.sv
segment_driver.sv
tail_light_top.sv
tail_light_asserts.sv
tail_light_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tail_light_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
